// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module dcache_tb -Mdir obj_dir -f compile.f
	./obj_dir/Vdcache_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/axi_pkg.sv
rtl/dcache_array_if.sv
rtl/dcache_arrays.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tb/axi_mem_model.sv
tb/dcache_properties.sv
tb/dcache_tb.sv

// ==== rtl/axi_pkg.sv ====
`include "dcache_config.svh"

package axi_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0] axi_addr_t;
    typedef logic [`DCACHE_DATA_W-1:0] axi_data_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [`DCACHE_DATA_W/8-1:0] axi_strb_t;

    // one full line per burst
    localparam axi_len_t BURST_LEN = axi_len_t'((1 << (`DCACHE_LEN_LINE - 2)) - 1);

    // 4 bytes per beat
    localparam axi_size_t SIZE_WORD = 3'd2;

endpackage

// ==== rtl/dcache_array_if.sv ====
interface dcache_array_if;
    import dcache_pkg::*;
    import axi_pkg::*;

    word_addr_t rd_addr;          // one cycle ram latency

    wmask_t     data_we;
    way_t       data_way;
    word_addr_t data_wr_addr;
    axi_data_t  data_wdata;
    logic       tag_we;
    tag_t       tag_wdata;

    logic       meta_set_valid;
    logic       meta_set_dirty;
    logic       meta_clr_dirty;
    logic       meta_touch;
    way_t       meta_way;

    logic       hit;
    way_t       hit_way;
    way_t       victim_way;       // lru way of the set
    logic       victim_dirty;
    axi_data_t  rd_data_hit;
    axi_data_t  rd_data_victim;
    tag_t       victim_tag;

    modport ctrl (
        output rd_addr, data_we, data_way, data_wr_addr, data_wdata, tag_we, tag_wdata,
        output meta_set_valid, meta_set_dirty, meta_clr_dirty, meta_touch, meta_way,
        input  hit, hit_way, victim_way, victim_dirty, rd_data_hit, rd_data_victim,
        input  victim_tag
    );

    modport arrays (
        input  rd_addr, data_we, data_way, data_wr_addr, data_wdata, tag_we, tag_wdata,
        input  meta_set_valid, meta_set_dirty, meta_clr_dirty, meta_touch, meta_way,
        output hit, hit_way, victim_way, victim_dirty, rd_data_hit, rd_data_victim,
        output victim_tag
    );

endinterface

// ==== rtl/dcache_arrays.sv ====
`include "dcache_config.svh"

module dcache_arrays (
    input  logic              clk,
    input  logic              rst,
    input  dcache_pkg::tag_t  req_tag,
    dcache_array_if.arrays    arr
);
    import dcache_pkg::*;
    import axi_pkg::*;

    localparam int NR_SETS  = 2 ** $bits(index_t);
    localparam int NR_WORDS = 2 ** $bits(word_addr_t);

    index_t rd_index;
    index_t wr_index;

    tag_t      way_tag  [`DCACHE_NR_WAYS];
    axi_data_t way_data [`DCACHE_NR_WAYS];
    logic [`DCACHE_NR_WAYS-1:0] match;

    logic [`DCACHE_NR_WAYS-1:0] valid_q [NR_SETS];
    logic [`DCACHE_NR_WAYS-1:0] dirty_q [NR_SETS];
    logic [NR_SETS-1:0]         lru_q;    // points at the way to replace

    assign rd_index = arr.rd_addr[$bits(word_addr_t)-1 -: $bits(index_t)];
    assign wr_index = arr.data_wr_addr[$bits(word_addr_t)-1 -: $bits(index_t)];

    for (genvar w = 0; w < `DCACHE_NR_WAYS; w++) begin : g_way
        axi_data_t data_mem [NR_WORDS];
        tag_t      tag_mem  [NR_SETS];
        axi_data_t data_rd;
        tag_t      tag_rd;

        always_ff @(posedge clk) begin
            for (int b = 0; b < $bits(wmask_t); b++) begin
                if (arr.data_we[b] && arr.data_way == way_t'(w)) begin
                    data_mem[arr.data_wr_addr][8*b +: 8] <= arr.data_wdata[8*b +: 8];
                end
            end
            if (arr.tag_we && arr.data_way == way_t'(w)) begin
                tag_mem[wr_index] <= arr.tag_wdata;
            end
            data_rd <= data_mem[arr.rd_addr];
            tag_rd  <= tag_mem[rd_index];
        end

        assign way_data[w] = data_rd;
        assign way_tag[w]  = tag_rd;
        assign match[w]    = valid_q[rd_index][w] && (tag_rd == req_tag);
    end

    assign arr.hit            = |match;
    assign arr.hit_way        = match[1];  // two ways only
    assign arr.victim_way     = lru_q[rd_index];
    assign arr.victim_dirty   = dirty_q[rd_index][arr.victim_way];
    assign arr.victim_tag     = way_tag[arr.victim_way];
    assign arr.rd_data_hit    = way_data[arr.hit_way];
    assign arr.rd_data_victim = way_data[arr.victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (arr.meta_set_valid) begin
                valid_q[rd_index][arr.meta_way] <= 1'b1;
            end
            if (arr.meta_set_dirty) begin
                dirty_q[rd_index][arr.meta_way] <= 1'b1;
            end else if (arr.meta_clr_dirty) begin
                dirty_q[rd_index][arr.meta_way] <= 1'b0;
            end
            if (arr.meta_touch) begin
                lru_q[rd_index] <= ~arr.meta_way;  // other way goes next
            end
        end
    end

endmodule

// ==== rtl/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte offset bits within a line, 64 byte lines
`define DCACHE_LEN_LINE 6

// set index bits, 64 sets
`define DCACHE_LEN_INDEX 6

// lru bit per set only covers two ways
`define DCACHE_NR_WAYS 2

`define DCACHE_ADDR_W 32
`define DCACHE_DATA_W 32

`endif

// ==== rtl/dcache_ctrl.sv ====
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_en,
    input  logic                mem_write,
    input  axi_pkg::axi_addr_t  mem_addr,
    input  dcache_pkg::wmask_t  mem_wmask,
    input  axi_pkg::axi_data_t  mem_wdata,
    output logic                dstall,
    output axi_pkg::axi_data_t  mem_rdata,
    output axi_pkg::axi_addr_t  araddr,
    output axi_pkg::axi_len_t   arlen,
    output axi_pkg::axi_size_t  arsize,
    output logic                arvalid,
    input  logic                arready,
    input  axi_pkg::axi_data_t  rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready,
    output axi_pkg::axi_addr_t  awaddr,
    output axi_pkg::axi_len_t   awlen,
    output axi_pkg::axi_size_t  awsize,
    output logic                awvalid,
    input  logic                awready,
    output axi_pkg::axi_data_t  wdata,
    output axi_pkg::axi_strb_t  wstrb,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    dcache_array_if.ctrl        arr
);
    import dcache_pkg::*;
    import axi_pkg::*;

    ctrl_state_t state;

    index_t     req_index;
    word_addr_t req_word;
    tag_t       req_tag;

    logic [$bits(word_off_t):0] fill_cnt;  // one extra step for the read latency
    logic       fill_done;
    word_off_t  beat;                      // w beats, then r beats
    word_off_t  beat_nx;
    way_t       vic_way;

    axi_data_t  line_buf [2 ** $bits(word_off_t)];

    assign req_index = mem_addr[`DCACHE_LEN_LINE +: `DCACHE_LEN_INDEX];
    assign req_word  = mem_addr[`DCACHE_LEN_LINE+`DCACHE_LEN_INDEX-1 -: $bits(word_addr_t)];
    assign req_tag   = mem_addr[`DCACHE_ADDR_W-1 -: $bits(tag_t)];
    assign fill_done = fill_cnt[$bits(word_off_t)];
    assign beat_nx   = beat + 1'b1;

    assign dstall    = mem_en && !(state == DONE && arr.hit);
    assign mem_rdata = arr.rd_data_hit;

    assign arlen  = BURST_LEN;
    assign arsize = SIZE_WORD;
    assign awlen  = BURST_LEN;
    assign awsize = SIZE_WORD;
    assign wstrb  = '1;

    // victim words come out of the ram during the fill
    assign arr.rd_addr = (state == WB_FILL_BUF) ?
                         {req_index, fill_cnt[$bits(word_off_t)-1:0]} : req_word;
    assign arr.tag_wdata = req_tag;

    always_comb begin
        arr.data_we        = '0;
        arr.data_way       = vic_way;
        arr.data_wr_addr   = req_word;
        arr.data_wdata     = mem_wdata;
        arr.tag_we         = 1'b0;
        arr.meta_set_valid = 1'b0;
        arr.meta_set_dirty = 1'b0;
        arr.meta_clr_dirty = 1'b0;
        arr.meta_touch     = 1'b0;
        arr.meta_way       = vic_way;
        case (state)
            DONE: begin
                if (arr.hit) begin
                    arr.data_way   = arr.hit_way;
                    arr.meta_way   = arr.hit_way;
                    arr.meta_touch = 1'b1;
                    if (mem_write) begin
                        arr.data_we        = mem_wmask;
                        arr.meta_set_dirty = 1'b1;
                    end
                end
            end
            WB_BURST: arr.meta_clr_dirty = bvalid;  // bready is tied high
            REFILL: begin
                if (rvalid && rready) begin
                    arr.data_we        = '1;
                    arr.data_wr_addr   = {req_index, beat};
                    arr.data_wdata     = rdata;
                    arr.tag_we         = rlast;
                    arr.meta_set_valid = rlast;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            arvalid  <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            wlast    <= 1'b0;
            rready   <= 1'b0;
            fill_cnt <= '0;
            beat     <= '0;
            vic_way  <= '0;
        end else begin
            case (state)
                IDLE: state <= LOOKUP;
                LOOKUP: begin
                    if (mem_en) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (arr.hit) begin
                        state <= LOOKUP;
                    end else if (arr.victim_dirty) begin
                        state    <= WB_FILL_BUF;
                        vic_way  <= arr.victim_way;
                        fill_cnt <= '0;
                    end else begin
                        state   <= REFILL;
                        vic_way <= arr.victim_way;
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        beat    <= '0;
                    end
                end
                WB_FILL_BUF: begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_done) begin
                        state   <= WB_BURST;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        wlast   <= 1'b0;
                        beat    <= '0;
                    end
                end
                WB_BURST: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        if (wlast) begin
                            wvalid <= 1'b0;
                            wlast  <= 1'b0;
                        end else begin
                            beat  <= beat_nx;
                            wlast <= (beat_nx == word_off_t'(BURST_LEN));
                        end
                    end
                    if (bvalid) begin
                        state   <= REFILL;
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        beat    <= '0;
                    end
                end
                REFILL: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (rvalid && rready) begin
                        beat <= beat_nx;
                        if (rlast) begin
                            rready <= 1'b0;
                            state  <= LOOKUP;  // looks up again, now a hit
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DONE && !arr.hit) begin
            awaddr <= {arr.victim_tag, req_index, {`DCACHE_LEN_LINE{1'b0}}};
            araddr <= {mem_addr[`DCACHE_ADDR_W-1:`DCACHE_LEN_LINE], {`DCACHE_LEN_LINE{1'b0}}};
        end
        if (state == WB_FILL_BUF && fill_cnt != '0) begin
            line_buf[word_off_t'(fill_cnt - 1'b1)] <= arr.rd_data_victim;
        end
        if (state == WB_FILL_BUF && fill_done) begin
            wdata <= line_buf[0];
        end
        if (state == WB_BURST && wvalid && wready && !wlast) begin
            wdata <= line_buf[beat_nx];
        end
    end

endmodule

// ==== rtl/dcache_pkg.sv ====
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-`DCACHE_LEN_INDEX-`DCACHE_LEN_LINE-1:0] tag_t;
    typedef logic [`DCACHE_LEN_INDEX-1:0] index_t;

    // word position in a line, byte offset bits minus the two in-word bits
    typedef logic [`DCACHE_LEN_LINE-3:0] word_off_t;

    // {index, word position}, one ram word per entry
    typedef logic [`DCACHE_LEN_INDEX+`DCACHE_LEN_LINE-3:0] word_addr_t;

    typedef logic [$clog2(`DCACHE_NR_WAYS)-1:0] way_t;
    typedef logic [`DCACHE_DATA_W/8-1:0] wmask_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,       // arrays read
        DONE,         // hit answered or miss detected
        WB_FILL_BUF,  // victim line copied to line buffer
        WB_BURST,     // aw + 16 w beats + b
        REFILL        // ar + 16 r beats into victim way
    } ctrl_state_t;

endpackage

// ==== rtl/dcache_top.sv ====
module dcache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_en,
    input  logic                mem_write,
    input  axi_pkg::axi_addr_t  mem_addr,
    input  dcache_pkg::wmask_t  mem_wmask,
    input  axi_pkg::axi_data_t  mem_wdata,
    output logic                dstall,
    output axi_pkg::axi_data_t  mem_rdata,
    output axi_pkg::axi_addr_t  araddr,
    output axi_pkg::axi_len_t   arlen,
    output axi_pkg::axi_size_t  arsize,
    output logic                arvalid,
    input  logic                arready,
    input  axi_pkg::axi_data_t  rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready,
    output axi_pkg::axi_addr_t  awaddr,
    output axi_pkg::axi_len_t   awlen,
    output axi_pkg::axi_size_t  awsize,
    output logic                awvalid,
    input  logic                awready,
    output axi_pkg::axi_data_t  wdata,
    output axi_pkg::axi_strb_t  wstrb,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready
);
    import dcache_pkg::*;
    import axi_pkg::*;

    tag_t req_tag;

    dcache_array_if arr_if ();

    assign req_tag = mem_addr[$bits(axi_addr_t)-1 -: $bits(tag_t)];
    assign bready  = 1'b1;  // b responses always taken

    dcache_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .mem_en    (mem_en),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wmask (mem_wmask),
        .mem_wdata (mem_wdata),
        .dstall    (dstall),
        .mem_rdata (mem_rdata),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .arr       (arr_if.ctrl)
    );

    dcache_arrays i_arrays (
        .clk     (clk),
        .rst     (rst),
        .req_tag (req_tag),
        .arr     (arr_if.arrays)
    );

endmodule

// ==== tb/axi_mem_model.sv ====
module axi_mem_model (
    input  logic               clk,
    input  logic               rst,
    input  axi_pkg::axi_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output axi_pkg::axi_data_t rdata,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,
    input  axi_pkg::axi_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    input  logic               wlast,
    input  logic               wvalid,
    output logic               wready,
    output logic               bvalid,
    input  logic               bready
);
    timeunit 1ns;
    timeprecision 100ps;
    import axi_pkg::*;

    axi_data_t mem [axi_addr_t];  // written words only, keyed by word address

    logic      rd_busy;
    axi_addr_t rd_base;
    int        rd_beat;
    int        r_gap;
    logic      aw_done;
    axi_addr_t wr_base;
    int        wr_beat;
    int        w_gap;

    function automatic axi_data_t read_word(input axi_addr_t byte_addr);
        axi_addr_t word_addr;
        word_addr = byte_addr >> 2;
        if (mem.exists(word_addr)) begin
            return mem[word_addr];
        end
        return word_addr ^ 32'h5a5a_0000;
    endfunction

    task automatic write_word(input axi_addr_t byte_addr, input axi_data_t data,
                              input axi_strb_t strb);
        axi_data_t word;
        word = read_word(byte_addr);
        for (int b = 0; b < $bits(axi_strb_t); b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[byte_addr >> 2] = word;
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
    end

    // read side: ar accepted after 0..3 idle cycles, same spacing between r beats
    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rd_busy <= 1'b0;
            rd_beat <= 0;
            r_gap   <= 0;
        end else begin
            arready <= 1'b0;
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_base <= araddr;
                rd_beat <= 0;
                r_gap   <= $urandom % 4;
            end else if (arvalid && !rd_busy) begin
                if (r_gap == 0) begin
                    arready <= 1'b1;
                end else begin
                    r_gap <= r_gap - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rlast   <= 1'b0;
                rd_beat <= rd_beat + 1;
                r_gap   <= $urandom % 4;
                if (rlast) begin
                    rd_busy <= 1'b0;
                end
            end else if (rd_busy && !rvalid) begin
                if (r_gap == 0) begin
                    rvalid <= 1'b1;
                    rlast  <= (rd_beat == int'(BURST_LEN));
                    rdata  <= read_word(rd_base + axi_addr_t'(4 * rd_beat));
                end else begin
                    r_gap <= r_gap - 1;
                end
            end
        end
    end

    // write side, w beats only taken once aw is in
    always @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_done <= 1'b0;
            wr_beat <= 0;
            w_gap   <= 0;
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (awvalid && awready) begin
                aw_done <= 1'b1;
                wr_base <= awaddr;
                wr_beat <= 0;
                w_gap   <= $urandom % 4;
            end else if (awvalid && !aw_done) begin
                if (w_gap == 0) begin
                    awready <= 1'b1;
                end else begin
                    w_gap <= w_gap - 1;
                end
            end
            if (wvalid && wready) begin
                write_word(wr_base + axi_addr_t'(4 * wr_beat), wdata, wstrb);
                wr_beat <= wr_beat + 1;
                w_gap   <= $urandom % 4;
                if (wlast) begin
                    aw_done <= 1'b0;
                    bvalid  <= 1'b1;
                end
            end else if (aw_done && wvalid) begin
                if (w_gap == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_gap <= w_gap - 1;
                end
            end
        end
    end

endmodule

// ==== tb/dcache_properties.sv ====
module dcache_properties (
    input logic clk,
    input logic rst,
    input logic arvalid,
    input logic arready,
    input logic rready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic wlast
);
    timeunit 1ns;
    timeprecision 100ps;

    // write-back burst and refill never overlap
    no_aw_in_refill: assert property (@(posedge clk) disable iff (rst) !(awvalid && rready))
        else $error("awvalid high while the refill takes r beats");

    ar_held: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    aw_held: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    w_held: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    wlast_with_wvalid: assert property (@(posedge clk) disable iff (rst) wlast |-> wvalid)
        else $error("wlast seen without wvalid");

endmodule

bind dcache_ctrl dcache_properties i_props (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .arready (arready),
    .rready  (rready),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .wlast   (wlast)
);

// ==== tb/dcache_tb.sv ====
`include "dcache_config.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import axi_pkg::*;

    // next line with the same set index
    localparam axi_addr_t SET_STRIDE = axi_addr_t'(1) << (`DCACHE_LEN_LINE + `DCACHE_LEN_INDEX);

    // one burst moves a whole line, one word per beat
    localparam int LINE_WORDS = (2 ** `DCACHE_LEN_LINE) / ($bits(axi_data_t) / 8);
    localparam int WORD_SIZE  = $clog2($bits(axi_data_t) / 8);

    typedef struct {
        string     name;
        logic      write;
        axi_addr_t addr;
        axi_strb_t mask;
        axi_data_t data;
        axi_data_t exp_rdata;
        int        exp_ar;
        int        exp_aw;
    } entry_t;

    logic      clk;
    logic      rst;
    logic      mem_en;
    logic      mem_write;
    axi_addr_t mem_addr;
    axi_strb_t mem_wmask;
    axi_data_t mem_wdata;
    logic      dstall;
    axi_data_t mem_rdata;
    axi_addr_t araddr;
    axi_len_t  arlen;
    axi_size_t arsize;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    logic      rlast;
    logic      rvalid;
    logic      rready;
    axi_addr_t awaddr;
    axi_len_t  awlen;
    axi_size_t awsize;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wlast;
    logic      wvalid;
    logic      wready;
    logic      bvalid;
    logic      bready;

    entry_t      table_q[$];
    axi_data_t   ref_mem [axi_addr_t];  // words written so far
    int          errors;
    int          checks;
    int          ar_count;
    int          aw_count;
    int          cycles;
    int          cycle_limit;

    dcache_top i_dut (.*);

    axi_mem_model i_mem (.*);

    always #20 clk = ~clk;

    function automatic axi_data_t read_reference(input axi_addr_t addr);
        axi_addr_t word_addr;
        word_addr = addr >> 2;
        if (ref_mem.exists(word_addr)) begin
            return ref_mem[word_addr];
        end
        return word_addr ^ 32'h5a5a_0000;  // untouched memory
    endfunction

    function automatic void merge_reference(input axi_addr_t addr, input axi_strb_t mask,
                                            input axi_data_t data);
        axi_data_t word;
        word = read_reference(addr);
        for (int b = 0; b < $bits(axi_strb_t); b++) begin
            if (mask[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        ref_mem[addr >> 2] = word;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic add_entry(input string name, input logic write, input axi_addr_t addr,
                             input axi_strb_t mask, input axi_data_t data,
                             input int exp_ar, input int exp_aw);
        entry_t e;
        e.name      = name;
        e.write     = write;
        e.addr      = addr;
        e.mask      = mask;
        e.data      = data;
        e.exp_ar    = exp_ar;
        e.exp_aw    = exp_aw;
        e.exp_rdata = '0;
        if (write) begin
            merge_reference(addr, mask, data);
        end else begin
            e.exp_rdata = read_reference(addr);
        end
        table_q.push_back(e);
    endtask

    task automatic build_table();
        axi_addr_t a;
        axi_addr_t d;
        a = 32'h0000_1040;  // set 1
        d = 32'h0000_10c0;  // set 3
        add_entry("read_miss", 1'b0, 32'h0000_0084, '0, '0, 1, 0);
        add_entry("read_same_line", 1'b0, 32'h0000_00bc, '0, '0, 0, 0);
        add_entry("write_partial", 1'b1, 32'h0000_0088, 4'b0101, 32'haabb_ccdd, 0, 0);
        add_entry("read_merged", 1'b0, 32'h0000_0088, '0, '0, 0, 0);
        add_entry("lru_read_a", 1'b0, a, '0, '0, 1, 0);
        add_entry("lru_read_b", 1'b0, a + SET_STRIDE + 4, '0, '0, 1, 0);
        add_entry("lru_read_a_again", 1'b0, a + 8, '0, '0, 0, 0);
        add_entry("lru_read_c", 1'b0, a + 2 * SET_STRIDE, '0, '0, 1, 0);
        add_entry("lru_a_kept", 1'b0, a + 12, '0, '0, 0, 0);
        add_entry("lru_b_refetched", 1'b0, a + SET_STRIDE, '0, '0, 1, 0);
        add_entry("dirty_write_d", 1'b1, d + 4, 4'hf, 32'h1234_5678, 1, 0);
        add_entry("dirty_touch_e", 1'b0, d + SET_STRIDE, '0, '0, 1, 0);
        add_entry("dirty_touch_f", 1'b0, d + 2 * SET_STRIDE, '0, '0, 1, 1);
        add_entry("dirty_read_d", 1'b0, d + 4, '0, '0, 1, 0);
        add_entry("dirty_read_d_neighbour", 1'b0, d + 60, '0, '0, 0, 0);
    endtask

    task automatic apply_entry(input entry_t e);
        int ar_before;
        int aw_before;
        @(negedge clk);
        ar_before = ar_count;
        aw_before = aw_count;
        mem_en    = 1'b1;
        mem_write = e.write;
        mem_addr  = e.addr;
        mem_wmask = e.mask;
        mem_wdata = e.data;
        do begin
            @(negedge clk);
        end while (dstall);
        if (!e.write) begin
            compare_values({e.name, " rdata"}, e.exp_rdata, mem_rdata);
        end
        compare_values({e.name, " ar bursts"}, e.exp_ar, ar_count - ar_before);
        compare_values({e.name, " aw bursts"}, e.exp_aw, aw_count - aw_before);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (arvalid && arready) begin
                ar_count <= ar_count + 1;
                compare_values("ar burst length", LINE_WORDS - 1, 32'(arlen));
                compare_values("ar burst size", WORD_SIZE, 32'(arsize));
            end
            if (awvalid && awready) begin
                aw_count <= aw_count + 1;
                compare_values("aw burst length", LINE_WORDS - 1, 32'(awlen));
                compare_values("aw burst size", WORD_SIZE, 32'(awsize));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd2d2_d6ab));
        clk         = 1'b0;
        rst         = 1'b1;
        mem_en      = 1'b0;
        mem_write   = 1'b0;
        mem_addr    = '0;
        mem_wmask   = '0;
        mem_wdata   = '0;
        errors      = 0;
        checks      = 0;
        ar_count    = 0;
        aw_count    = 0;
        cycles      = 0;
        cycle_limit = 0;
        build_table();
        cycle_limit = 200 * table_q.size();

        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_values("reset arvalid", 32'd0, 32'(arvalid));
        compare_values("reset awvalid", 32'd0, 32'(awvalid));
        compare_values("reset wvalid", 32'd0, 32'(wvalid));
        compare_values("reset wlast", 32'd0, 32'(wlast));
        compare_values("reset rready", 32'd0, 32'(rready));
        compare_values("reset dstall", 32'd0, 32'(dstall));
        compare_values("bready tied high", 32'd1, 32'(bready));

        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        @(negedge clk);
        mem_en = 1'b0;

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
